// ==== fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and instruction width
`define FETCH_XLEN 32

// fetch queue depth must be a power of two
`define FETCH_QUEUE_DEPTH 16
`define FETCH_QUEUE_PTR_W 4

// branch predictor table
`define BP_ENTRIES 16
`define BP_INDEX_W 4

// word addressed instruction memory
`define IMEM_WORDS 256
`define IMEM_ADDR_W 8

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// ==== fetch_pkg.sv ====
`default_nettype none
`include "fetch_consts.svh"

package fetch_pkg;

    // request from the fetch queue to instruction memory
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] addr;
    } mem_req_t;

    // memory read data, tagged with the address it came from
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] addr;
        logic [`FETCH_XLEN-1:0] inst;
    } mem_resp_t;

    // instruction handed to decode
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] addr;
        logic [`FETCH_XLEN-1:0] inst;
        logic [31:0]            inst_id;
    } fetch_resp_t;

    // misprediction restart from decode
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] addr;
    } redirect_t;

    // resolved branch outcome for predictor training
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic                   taken;
        logic [`FETCH_XLEN-1:0] target;
    } bp_update_t;

    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } bp_ctr_e;

endpackage

`default_nettype wire

// ==== branch_predictor.sv ====
`default_nettype none
`include "fetch_consts.svh"

module branch_predictor (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic [`FETCH_XLEN-1:0] fetch_pc,
    input  wire fetch_pkg::bp_update_t  bp_update,
    output logic [`FETCH_XLEN-1:0]      pred_next_pc
);

    localparam int TAG_W = `FETCH_XLEN - `BP_INDEX_W - 2;

    logic                   entry_valid  [`BP_ENTRIES];
    logic [TAG_W-1:0]       entry_tag    [`BP_ENTRIES];
    logic [`FETCH_XLEN-1:0] entry_target [`BP_ENTRIES];
    fetch_pkg::bp_ctr_e     entry_ctr    [`BP_ENTRIES];

    logic [`BP_INDEX_W-1:0] rd_idx;
    logic [TAG_W-1:0]       rd_tag;
    logic                   rd_hit;

    logic [`BP_INDEX_W-1:0] upd_idx;
    logic [TAG_W-1:0]       upd_tag;
    logic                   upd_hit;
    fetch_pkg::bp_ctr_e     upd_base;

    // saturating step of the two-bit counter
    function automatic fetch_pkg::bp_ctr_e ctr_step(input fetch_pkg::bp_ctr_e cur,
                                                    input logic taken);
        fetch_pkg::bp_ctr_e nxt;
        case (cur)
            fetch_pkg::strong_not_taken:
                nxt = taken ? fetch_pkg::weak_not_taken : fetch_pkg::strong_not_taken;
            fetch_pkg::weak_not_taken:
                nxt = taken ? fetch_pkg::weak_taken : fetch_pkg::strong_not_taken;
            fetch_pkg::weak_taken:
                nxt = taken ? fetch_pkg::strong_taken : fetch_pkg::weak_not_taken;
            default:
                nxt = taken ? fetch_pkg::strong_taken : fetch_pkg::weak_taken;
        endcase
        return nxt;
    endfunction

    // lookup for the address being fetched
    always_comb begin
        rd_idx = fetch_pc[`BP_INDEX_W+1:2];
        rd_tag = fetch_pc[`FETCH_XLEN-1:`BP_INDEX_W+2];
        rd_hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
        if (rd_hit && (entry_ctr[rd_idx] == fetch_pkg::weak_taken ||
                       entry_ctr[rd_idx] == fetch_pkg::strong_taken)) begin
            pred_next_pc = entry_target[rd_idx];
        end else begin
            pred_next_pc = fetch_pc + `FETCH_XLEN'(4);
        end
    end

    always_comb begin
        upd_idx  = bp_update.pc[`BP_INDEX_W+1:2];
        upd_tag  = bp_update.pc[`FETCH_XLEN-1:`BP_INDEX_W+2];
        upd_hit  = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_tag);
        // a fresh allocation counts from weak not taken
        upd_base = upd_hit ? entry_ctr[upd_idx] : fetch_pkg::weak_not_taken;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
                entry_ctr[i]   <= fetch_pkg::weak_not_taken;
            end
        end else if (bp_update.valid) begin
            entry_valid[upd_idx] <= 1'b1;
            entry_ctr[upd_idx]   <= ctr_step(upd_base, bp_update.taken);
        end
    end

    // keep a known target on a not-taken hit
    always_ff @(posedge clk) begin
        if (bp_update.valid) begin
            entry_tag[upd_idx] <= upd_tag;
            if (bp_update.taken || !upd_hit) begin
                entry_target[upd_idx] <= bp_update.target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== inst_mem.sv ====
`default_nettype none
`include "fetch_consts.svh"

module inst_mem (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire fetch_pkg::mem_req_t    mem_req,
    output logic                        mem_req_ready,
    output fetch_pkg::mem_resp_t        mem_resp,
    input  wire logic                   mem_stall,
    input  wire logic                   imem_load_en,
    input  wire logic [`IMEM_ADDR_W-1:0] imem_load_addr,
    input  wire logic [`FETCH_XLEN-1:0] imem_load_data
);

    logic [`FETCH_XLEN-1:0]  mem [`IMEM_WORDS];

    logic [`IMEM_ADDR_W-1:0] rd_idx;
    logic                    accept;

    logic                    resp_valid;
    logic [`FETCH_XLEN-1:0]  resp_addr;
    logic [`FETCH_XLEN-1:0]  resp_inst;

    always_comb begin
        mem_req_ready = !mem_stall;
        accept        = mem_req.valid && mem_req_ready;
        // byte address to word index
        rd_idx        = mem_req.addr[`IMEM_ADDR_W+1:2];
    end

    // program load port
    always_ff @(posedge clk) begin
        if (imem_load_en) begin
            mem[imem_load_addr] <= imem_load_data;
        end
    end

    // read data and its address one cycle after acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_addr <= mem_req.addr;
            resp_inst <= mem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    always_comb begin
        mem_resp.valid = resp_valid;
        mem_resp.addr  = resp_addr;
        mem_resp.inst  = resp_inst;
    end

endmodule

`default_nettype wire

// ==== inst_fetch_queue.sv ====
`default_nettype none
`include "fetch_consts.svh"

module inst_fetch_queue (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire fetch_pkg::redirect_t   redirect,
    output fetch_pkg::fetch_resp_t      fetch_out,
    input  wire logic                   fetch_ready,
    output fetch_pkg::mem_req_t         mem_req,
    input  wire logic                   mem_req_ready,
    input  wire fetch_pkg::mem_resp_t   mem_resp,
    output logic [`FETCH_XLEN-1:0]      fetch_pc,
    input  wire logic [`FETCH_XLEN-1:0] pred_next_pc
);

    localparam int PTR_W = `FETCH_QUEUE_PTR_W;
    // stop requesting with fewer than two free slots,
    // which leaves room for the response in flight
    localparam logic [PTR_W-1:0] FULL_LEVEL = PTR_W'(`FETCH_QUEUE_DEPTH - 2);

    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] request_pc;
    logic                   requested;
    logic [31:0]            inst_id;

    logic [PTR_W-1:0]       head;
    logic [PTR_W-1:0]       tail;
    logic [PTR_W-1:0]       used;
    logic [`FETCH_XLEN-1:0] addr_q [`FETCH_QUEUE_DEPTH];
    logic [`FETCH_XLEN-1:0] inst_q [`FETCH_QUEUE_DEPTH];

    logic queue_empty;
    logic queue_full;
    logic resp_match;
    logic flush;
    logic req_fire;
    logic out_fire;

    assign fetch_pc = pc;

    always_comb begin
        used        = tail - head;
        queue_empty = (head == tail);
        queue_full  = (used >= FULL_LEVEL);
        // stale responses from before a redirect fall out here
        resp_match  = requested && mem_resp.valid && (mem_resp.addr == request_pc);
    end

    // a redirect to the address already in flight with nothing buffered
    // is only a slow fetch, so it keeps the request going
    always_comb begin
        flush = redirect.valid &&
                (!requested || (request_pc != redirect.addr) || !queue_empty);
    end

    always_comb begin
        mem_req.valid = !queue_full && !flush;
        mem_req.addr  = pc;
        req_fire      = mem_req.valid && mem_req_ready;
    end

    // empty queue passes the matching response straight through
    always_comb begin
        fetch_out.valid   = (!queue_empty || resp_match) && !flush;
        fetch_out.addr    = queue_empty ? mem_resp.addr : addr_q[head];
        fetch_out.inst    = queue_empty ? mem_resp.inst : inst_q[head];
        fetch_out.inst_id = inst_id;
        out_fire          = fetch_out.valid && fetch_ready;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `FETCH_RESET_PC;
            requested <= 1'b0;
            head      <= '0;
            tail      <= '0;
            inst_id   <= '0;
        end else if (flush) begin
            // drop everything buffered and the response in flight
            head      <= tail;
            pc        <= redirect.addr;
            requested <= 1'b0;
            inst_id   <= inst_id + 32'd1;
        end else begin
            if (req_fire) begin
                requested <= 1'b1;
                pc        <= pred_next_pc;
            end else if (resp_match) begin
                requested <= 1'b0;
            end

            // a bypassed word is written too, head steps over it below
            if (resp_match) begin
                tail <= tail + PTR_W'(1);
            end

            if (out_fire) begin
                head    <= head + PTR_W'(1);
                inst_id <= inst_id + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            request_pc <= pc;
        end
        if (resp_match && !flush) begin
            addr_q[tail] <= mem_resp.addr;
            inst_q[tail] <= mem_resp.inst;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire fetch_pkg::redirect_t    redirect,
    input  wire fetch_pkg::bp_update_t   bp_update,
    output fetch_pkg::fetch_resp_t       fetch_out,
    input  wire logic                    fetch_ready,
    input  wire logic                    mem_stall,
    input  wire logic                    imem_load_en,
    input  wire logic [`IMEM_ADDR_W-1:0] imem_load_addr,
    input  wire logic [`FETCH_XLEN-1:0]  imem_load_data
);

    fetch_pkg::mem_req_t    mem_req;
    logic                   mem_req_ready;
    fetch_pkg::mem_resp_t   mem_resp;
    logic [`FETCH_XLEN-1:0] fetch_pc;
    logic [`FETCH_XLEN-1:0] pred_next_pc;

    inst_fetch_queue inst_fetch_queue_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .redirect      (redirect),
        .fetch_out     (fetch_out),
        .fetch_ready   (fetch_ready),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_resp      (mem_resp),
        .fetch_pc      (fetch_pc),
        .pred_next_pc  (pred_next_pc)
    );

    // next pc choice for the queue
    branch_predictor branch_predictor_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_pc     (fetch_pc),
        .bp_update    (bp_update),
        .pred_next_pc (pred_next_pc)
    );

    inst_mem inst_mem_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp       (mem_resp),
        .mem_stall      (mem_stall),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== fetch_unit_tb.sv ====
`default_nettype none
`include "fetch_consts.svh"

module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS        = 6;
    localparam int WAIT_LIMIT      = 100;
    localparam int STALL_START     = 2;
    localparam int STALL_LEN       = 6;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + `IMEM_WORDS;

    logic                    clk;
    logic                    rst_n;
    fetch_pkg::redirect_t    redirect;
    fetch_pkg::bp_update_t   bp_update;
    fetch_pkg::fetch_resp_t  fetch_out;
    logic                    fetch_ready;
    logic                    mem_stall;
    logic                    imem_load_en;
    logic [`IMEM_ADDR_W-1:0] imem_load_addr;
    logic [`FETCH_XLEN-1:0]  imem_load_data;

    // scenario table with one index per row
    string                  row_name     [NUM_ROWS];
    logic                   row_redirect [NUM_ROWS];
    logic [`FETCH_XLEN-1:0] row_target   [NUM_ROWS];
    int                     row_num_upd  [NUM_ROWS];
    fetch_pkg::bp_update_t  row_upd      [NUM_ROWS][2];
    int                     row_num_exp  [NUM_ROWS];
    logic [`FETCH_XLEN-1:0] row_exp      [NUM_ROWS][8];
    logic                   row_throttle [NUM_ROWS];
    logic                   row_stall    [NUM_ROWS];

    logic [`FETCH_XLEN-1:0] prog_words [`IMEM_WORDS];
    logic [31:0]            expected_id;
    integer                 seed;
    int                     test_errors;
    int                     tests_failed;
    int                     checks_done;
    int                     r;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) tb_clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_unit fetch_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .bp_update      (bp_update),
        .fetch_out      (fetch_out),
        .fetch_ready    (fetch_ready),
        .mem_stall      (mem_stall),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data)
    );

    task automatic set_row(input int idx, input string name, input logic redir,
                           input logic [`FETCH_XLEN-1:0] target, input logic throttle,
                           input logic stall);
        row_name[idx]     = name;
        row_redirect[idx] = redir;
        row_target[idx]   = target;
        row_throttle[idx] = throttle;
        row_stall[idx]    = stall;
        row_num_upd[idx]  = 0;
        row_num_exp[idx]  = 0;
    endtask

    task automatic add_update(input int idx, input logic [`FETCH_XLEN-1:0] pc,
                              input logic taken, input logic [`FETCH_XLEN-1:0] target);
        fetch_pkg::bp_update_t upd;
        upd.valid  = 1'b1;
        upd.pc     = pc;
        upd.taken  = taken;
        upd.target = target;
        row_upd[idx][row_num_upd[idx]] = upd;
        row_num_upd[idx]++;
    endtask

    // sequential addresses as the predictor gives them on a miss
    task automatic add_run(input int idx, input logic [`FETCH_XLEN-1:0] start, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            row_exp[idx][row_num_exp[idx]] = start + `FETCH_XLEN'(4 * i);
            row_num_exp[idx]++;
        end
    endtask

    task automatic build_table();
        set_row(0, "reset_stream", 1'b0, '0, 1'b0, 1'b0);
        add_run(0, `FETCH_RESET_PC, 8);
        set_row(1, "ready_throttle", 1'b0, '0, 1'b1, 1'b0);
        add_run(1, `FETCH_RESET_PC + 32'h20, 8);
        set_row(2, "redirect", 1'b1, 32'h100, 1'b0, 1'b0);
        add_run(2, 32'h100, 4);
        // one taken step from weak not taken already predicts taken
        set_row(3, "predict_taken", 1'b1, 32'h1f8, 1'b0, 1'b0);
        add_update(3, 32'h200, 1'b1, 32'h340);
        add_run(3, 32'h1f8, 3);
        add_run(3, 32'h340, 2);
        set_row(4, "predict_restore", 1'b1, 32'h1f8, 1'b0, 1'b0);
        add_update(4, 32'h200, 1'b0, 32'h340);
        add_update(4, 32'h200, 1'b0, 32'h340);
        add_run(4, 32'h1f8, 5);
        set_row(5, "mem_stall", 1'b1, 32'h080, 1'b0, 1'b1);
        add_run(5, 32'h080, 6);
    endtask

    // memory held stalled until every word is written
    task automatic load_program();
        int n;
        for (n = 0; n < `IMEM_WORDS; n++) begin
            prog_words[n] = $random(seed);
            prog_words[n] = prog_words[n] ^ 32'(n);
        end
        for (n = 0; n < `IMEM_WORDS; n++) begin
            @(posedge clk);
            #1;
            imem_load_en   = 1'b1;
            imem_load_addr = `IMEM_ADDR_W'(n);
            imem_load_data = prog_words[n];
        end
        @(posedge clk);
        #1;
        imem_load_en = 1'b0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        mem_stall = 1'b0;
    endtask

    task automatic check_pc(input string name, input logic [`FETCH_XLEN-1:0] expected,
                            input logic [`FETCH_XLEN-1:0] actual);
        checks_done++;
        if (actual !== expected) begin
            $display("Fail %s: pc expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_resp(input string name, input fetch_pkg::fetch_resp_t expected,
                              input fetch_pkg::fetch_resp_t actual);
        checks_done++;
        if (actual !== expected) begin
            $display("Fail %s: expected addr %h inst %h id %0d actual addr %h inst %h id %0d",
                     name, expected.addr, expected.inst, expected.inst_id,
                     actual.addr, actual.inst, actual.inst_id);
            test_errors++;
        end
    endtask

    task automatic report_problem(input string name, input string what);
        $display("test %s: %s", name, what);
        test_errors++;
    endtask

    task automatic run_row(input int idx);
        string                  name;
        fetch_pkg::fetch_resp_t got;
        fetch_pkg::fetch_resp_t exp_resp;
        logic [31:0]            rnd;
        logic                   stall_now;
        logic                   drained;
        int                     u;
        int                     cyc;
        int                     got_count;
        name        = row_name[idx];
        test_errors = 0;
        for (u = 0; u < row_num_upd[idx]; u++) begin
            bp_update = row_upd[idx][u];
            @(posedge clk);
            #1;
        end
        bp_update = '0;
        if (row_redirect[idx]) begin
            // a buffered entry guarantees the redirect flushes
            cyc = 0;
            @(negedge clk);
            while (!fetch_out.valid && cyc < WAIT_LIMIT) begin
                @(negedge clk);
                cyc++;
            end
            if (!fetch_out.valid)
                report_problem(name, "queue never filled before the redirect");
            @(posedge clk);
            #1;
            redirect.valid = 1'b1;
            redirect.addr  = row_target[idx];
            @(negedge clk);
            if (fetch_out.valid)
                report_problem(name, "instruction offered in the redirect cycle");
            expected_id = expected_id + 32'd1;
            @(posedge clk);
            #1;
            redirect = '0;
        end
        cyc       = 0;
        got_count = 0;
        drained   = 1'b0;
        while (got_count < row_num_exp[idx] && cyc < WAIT_LIMIT) begin
            stall_now = row_stall[idx] && cyc >= STALL_START && cyc < STALL_START + STALL_LEN;
            mem_stall = stall_now;
            rnd       = $random(seed);
            fetch_ready = row_throttle[idx] ? rnd[0] : 1'b1;
            @(negedge clk);
            got = fetch_out;
            if (stall_now) begin
                if (drained && got.valid)
                    report_problem(name, "instruction delivered after the queue drained");
                if (!got.valid)
                    drained = 1'b1;
                if (cyc == STALL_START + STALL_LEN - 1 && !drained)
                    report_problem(name, "queue still delivering at the end of the stall");
            end
            if (got.valid && fetch_ready) begin
                exp_resp.valid   = 1'b1;
                exp_resp.addr    = row_exp[idx][got_count];
                exp_resp.inst    = prog_words[exp_resp.addr[`IMEM_ADDR_W+1:2]];
                exp_resp.inst_id = expected_id;
                check_pc(name, exp_resp.addr, got.addr);
                check_resp(name, exp_resp, got);
                expected_id = expected_id + 32'd1;
                got_count++;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        fetch_ready = 1'b0;
        mem_stall   = 1'b0;
        if (got_count < row_num_exp[idx])
            report_problem(name, "timed out waiting for instructions");
    endtask

    initial begin
        redirect       = '0;
        bp_update      = '0;
        fetch_ready    = 1'b0;
        mem_stall      = 1'b1;
        imem_load_en   = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;
        seed           = 52942;
        expected_id    = '0;
        tests_failed   = 0;
        checks_done    = 0;
        build_table();
        load_program();
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
            if (test_errors == 0) begin
                $display("test %s: passed", row_name[r]);
            end else begin
                $display("test %s: failed with %0d errors", row_name[r], test_errors);
                tests_failed++;
            end
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d checks",
                 NUM_ROWS, NUM_ROWS - tests_failed, tests_failed, checks_done);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run stopped after %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
fetch_pkg.sv
branch_predictor.sv
inst_mem.sv
inst_fetch_queue.sv
fetch_unit.sv
tb_clock_gen.sv
fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module fetch_unit_tb -Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/Vfetch_unit_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log_file"; then
    echo "result: failure reported, see $log_file"
    exit 1
fi

echo "result: no failure reported"
exit 0
